// ==== logic/slurm16_config.svh ====
/* Width macros and link register numbers for the slurm16 backend */
`ifndef SLURM16_CONFIG_SVH
`define SLURM16_CONFIG_SVH

// Data and instruction word
`define SLURM16_BITS 16

`define SLURM16_ADDRESS_BITS 16

// 16 registers, r0 reads zero
`define SLURM16_REGISTER_BITS 4

`define SLURM16_LINK_REGISTER 4'd15	// Branch and link target

`define SLURM16_INTERRUPT_LINK_REGISTER 4'd14	// Interrupt return address

`endif

// ==== logic/slurm16_pkg.sv ====
/* Instruction classes, field positions and field helpers,
 * the slot descriptor struct and the byte lane rule */
`include "slurm16_config.svh"

package slurm16_pkg;

	localparam int CLASS_BITS = 4;
	localparam int CLASS_LSB = 12;	// Bits 15..12
	localparam int DEST_LSB = 8;	// Bits 11..8
	localparam int SRC_LSB = 4;	// Bits 7..4
	localparam int DEST3_LSB = 0;	// Three register conditional ALU
	localparam int STORE_BIT = 3;	// Store / poke select
	localparam int LINK_BIT = 0;	// Branch with link

	typedef enum logic [CLASS_BITS-1:0] {
		NOP          = 4'd0,
		ALU_SINGLE   = 4'd1,
		ALU_REG      = 4'd2,
		BRANCH       = 4'd3,
		BYTE_LS      = 4'd4,
		BYTE_LOAD_SX = 4'd5,
		WORD_LS      = 4'd6,
		PEEK_POKE    = 4'd7,
		INTERRUPT    = 4'd8,
		COND_MOV     = 4'd9,
		COND_ALU3    = 4'd10
	} instr_class_t;

	// Instruction in pipeline slot 4 with everything retirement needs
	typedef struct packed {
		logic [`SLURM16_BITS-1:0] instruction;
		logic [`SLURM16_BITS-1:0] alu_out;
		logic [`SLURM16_ADDRESS_BITS-1:0] pc;
		logic [`SLURM16_ADDRESS_BITS-1:0] mem_addr;
		logic cond_pass;
		logic is_nop;
		logic irq_return;
	} slot_t;

	function automatic instr_class_t class_of(input logic [`SLURM16_BITS-1:0] ins);
		return instr_class_t'(ins[CLASS_LSB +: CLASS_BITS]);
	endfunction

	function automatic logic [`SLURM16_REGISTER_BITS-1:0] dest_of(
		input logic [`SLURM16_BITS-1:0] ins);
		return ins[DEST_LSB +: `SLURM16_REGISTER_BITS];
	endfunction

	function automatic logic [`SLURM16_REGISTER_BITS-1:0] src_of(
		input logic [`SLURM16_BITS-1:0] ins);
		return ins[SRC_LSB +: `SLURM16_REGISTER_BITS];
	endfunction

	function automatic logic [`SLURM16_REGISTER_BITS-1:0] dest3_of(
		input logic [`SLURM16_BITS-1:0] ins);
		return ins[DEST3_LSB +: `SLURM16_REGISTER_BITS];
	endfunction

	function automatic logic is_store(input logic [`SLURM16_BITS-1:0] ins);
		return ins[STORE_BIT];
	endfunction

	function automatic logic is_link(input logic [`SLURM16_BITS-1:0] ins);
		return ins[LINK_BIT];
	endfunction

	// Even address is the high byte
	function automatic logic [1:0] lane_mask(input logic [`SLURM16_ADDRESS_BITS-1:0] addr);
		return addr[0] ? 2'b01 : 2'b10;
	endfunction

endpackage

// ==== logic/slurm16_backend_ifs.sv ====
/* load_if between sequencer and load unit,
 * regwrite_if between writeback and register file */
`include "slurm16_config.svh"

interface load_if;
	logic start;	// Held until done
	logic [`SLURM16_ADDRESS_BITS-1:0] addr;
	logic is_port;
	logic done;
	logic [`SLURM16_BITS-1:0] data;

	modport ctrl(output start, output addr, output is_port, input done);
	modport unit(input start, input addr, input is_port, output done, output data);
endinterface

interface regwrite_if;
	logic wr_en;	// One cycle strobe from the sequencer
	logic [`SLURM16_REGISTER_BITS-1:0] wr_sel;
	logic [`SLURM16_BITS-1:0] wr_data;

	modport source(output wr_sel, output wr_data);
	modport sink(input wr_en, input wr_sel, input wr_data);
endinterface

// ==== logic/slurm16_stage_control.sv ====
/* Retirement sequencer: input four-phase handshake FSM,
 * slot latch, load request and register write strobe */
`include "slurm16_config.svh"

module slurm16_stage_control (
	input  logic clk,
	input  logic reset,
	input  logic in_req,
	output logic in_ack,
	input  slurm16_pkg::slot_t slot_in,
	output slurm16_pkg::slot_t slot,
	output logic wr_en,
	load_if.ctrl load
);

	typedef enum logic [2:0] {
		IDLE,
		LATCH,
		LOAD,
		WRITE,
		ACK,
		RELEASE
	} state_t;

	state_t state;
	slurm16_pkg::instr_class_t cls;
	logic is_read;
	logic needs_read;

	assign cls = slurm16_pkg::class_of(slot.instruction);

	// Loads, sign extending byte loads and peeks go to the bus
	always_comb begin
		case (cls)
			slurm16_pkg::BYTE_LS, slurm16_pkg::WORD_LS, slurm16_pkg::PEEK_POKE: begin
				is_read = !slurm16_pkg::is_store(slot.instruction);
			end
			slurm16_pkg::BYTE_LOAD_SX: begin
				is_read = 1'b1;
			end
			default: begin
				is_read = 1'b0;
			end
		endcase
	end

	// A nop or an interrupt return never uses the loaded word
	assign needs_read = is_read && !slot.is_nop && !slot.irq_return;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (in_req) begin
						state <= LATCH;
					end
				end
				LATCH: begin
					state <= needs_read ? LOAD : WRITE;
				end
				LOAD: begin
					if (load.done) begin
						state <= WRITE;
					end
				end
				WRITE: begin
					state <= ACK;
				end
				ACK: begin
					if (!in_req) begin	// Source released, drop ack
						state <= RELEASE;
					end
				end
				RELEASE: begin
					state <= IDLE;
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && in_req) begin
			slot <= slot_in;	// Source holds fields while req is high
		end
	end

	assign in_ack = (state == ACK);
	assign wr_en = (state == WRITE);
	assign load.start = (state == LOAD);
	assign load.addr = slot.mem_addr;
	assign load.is_port = (cls == slurm16_pkg::PEEK_POKE);

	a_ack_after_req: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) |-> in_req && $past(in_req, 3));

endmodule

// ==== logic/slurm16_load_unit.sv ====
/* Four-phase read master for the memory and port bus,
 * holds the captured word for writeback */
`include "slurm16_config.svh"

module slurm16_load_unit (
	input  logic clk,
	input  logic reset,
	load_if.unit load,
	output logic mem_req,
	input  logic mem_ack,
	output logic [`SLURM16_ADDRESS_BITS-1:0] mem_addr,
	output logic mem_is_port,
	input  logic [`SLURM16_BITS-1:0] mem_rdata
);

	typedef enum logic [1:0] {
		IDLE,
		REQ,
		ACK_LOW,
		DONE
	} state_t;

	state_t state;
	logic [`SLURM16_BITS-1:0] data_q;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE: begin
					if (load.start) begin
						state <= REQ;
					end
				end
				REQ: begin
					if (mem_ack) begin	// Data valid with ack
						state <= ACK_LOW;
					end
				end
				ACK_LOW: begin
					if (!mem_ack) begin
						state <= DONE;
					end
				end
				DONE: begin
					if (!load.start) begin	// Sequencer closes its own handshake
						state <= IDLE;
					end
				end
				default: begin
					state <= IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (state == IDLE && load.start) begin
			mem_addr <= load.addr;
			mem_is_port <= load.is_port;
		end
		if (state == REQ && mem_ack) begin
			data_q <= mem_rdata;
		end
	end

	assign mem_req = (state == REQ);
	assign load.done = (state == DONE);
	assign load.data = data_q;

	a_addr_stable: assert property (@(posedge clk) disable iff (reset)
		(mem_req && $past(mem_req)) |-> $stable(mem_addr));

endmodule

// ==== logic/slurm16_cpu_writeback.sv ====
/* Writeback select: destination register and value
 * from ALU result, loaded word, byte lane or pc */
`include "slurm16_config.svh"

module slurm16_cpu_writeback (
	input  slurm16_pkg::slot_t slot,
	input  logic [`SLURM16_BITS-1:0] load_data,
	input  logic [1:0] lane_mask,
	regwrite_if.source wb
);

	logic [7:0] lane;
	logic [`SLURM16_REGISTER_BITS-1:0] dest;

	assign dest = slurm16_pkg::dest_of(slot.instruction);

	always_comb begin
		case (lane_mask)
			2'b10: begin
				lane = load_data[15:8];
			end
			2'b01: begin
				lane = load_data[7:0];
			end
			default: begin
				lane = 8'h00;
			end
		endcase
	end

	always_comb begin
		wb.wr_sel = '0;	// r0 swallows anything written to it
		wb.wr_data = '0;

		if (slot.irq_return) begin
			wb.wr_sel = `SLURM16_INTERRUPT_LINK_REGISTER;
			wb.wr_data = slot.pc;
		end else if (!slot.is_nop) begin
			case (slurm16_pkg::class_of(slot.instruction))
				slurm16_pkg::ALU_SINGLE: begin
					wb.wr_sel = slurm16_pkg::src_of(slot.instruction);
					wb.wr_data = slot.alu_out;
				end
				slurm16_pkg::ALU_REG: begin
					wb.wr_sel = dest;
					wb.wr_data = slot.alu_out;
				end
				slurm16_pkg::BRANCH: begin
					if (slurm16_pkg::is_link(slot.instruction)) begin
						wb.wr_sel = `SLURM16_LINK_REGISTER;
						wb.wr_data = slot.pc + `SLURM16_ADDRESS_BITS'(2);	// Return past branch
					end
				end
				slurm16_pkg::BYTE_LS: begin
					if (!slurm16_pkg::is_store(slot.instruction)) begin
						wb.wr_sel = dest;
						wb.wr_data = {8'h00, lane};
					end
				end
				slurm16_pkg::BYTE_LOAD_SX: begin
					wb.wr_sel = dest;
					wb.wr_data = {{8{lane[7]}}, lane};
				end
				slurm16_pkg::WORD_LS: begin
					if (!slurm16_pkg::is_store(slot.instruction)) begin
						wb.wr_sel = dest;
						wb.wr_data = load_data;
					end
				end
				slurm16_pkg::PEEK_POKE: begin
					if (!slurm16_pkg::is_store(slot.instruction)) begin	// Peek only
						wb.wr_sel = dest;
						wb.wr_data = load_data;
					end
				end
				slurm16_pkg::INTERRUPT: begin
					wb.wr_sel = `SLURM16_INTERRUPT_LINK_REGISTER;
					wb.wr_data = slot.pc;
				end
				slurm16_pkg::COND_MOV: begin
					if (slot.cond_pass) begin
						wb.wr_sel = dest;
						wb.wr_data = slot.alu_out;
					end
				end
				slurm16_pkg::COND_ALU3: begin
					if (slot.cond_pass) begin
						wb.wr_sel = slurm16_pkg::dest3_of(slot.instruction);
						wb.wr_data = slot.alu_out;
					end
				end
				default: begin
				end
			endcase
		end
	end

endmodule

// ==== logic/slurm16_register_file.sv ====
/* 16 x 16 register file, r0 fixed at zero,
 * one write port and one combinational read port */
`include "slurm16_config.svh"

module slurm16_register_file (
	input  logic clk,
	input  logic reset,
	regwrite_if.sink wb,
	input  logic [`SLURM16_REGISTER_BITS-1:0] rd_sel,
	output logic [`SLURM16_BITS-1:0] rd_data
);

	localparam int NUM_REGS = 1 << `SLURM16_REGISTER_BITS;

	logic [`SLURM16_BITS-1:0] regs [NUM_REGS];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < NUM_REGS; i++) begin
				regs[i] <= '0;
			end
		end else if (wb.wr_en && wb.wr_sel != '0) begin	// Writes to r0 dropped
			regs[wb.wr_sel] <= wb.wr_data;
		end
	end

	assign rd_data = regs[rd_sel];

	a_r0_zero: assert property (@(posedge clk) disable iff (reset)
		regs[0] == '0);

endmodule

// ==== logic/slurm16_backend.sv ====
/* Retirement backend top: sequencer, load unit,
 * writeback select and register file */
`include "slurm16_config.svh"

module slurm16_backend (
	input  logic clk,
	input  logic reset,
	input  logic in_req,
	output logic in_ack,
	input  logic [`SLURM16_BITS-1:0] in_instruction,
	input  logic [`SLURM16_BITS-1:0] in_alu_out,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] in_pc,
	input  logic [`SLURM16_ADDRESS_BITS-1:0] in_mem_addr,
	input  logic in_cond_pass,
	input  logic in_is_nop,
	input  logic in_irq_return,
	output logic mem_req,
	input  logic mem_ack,
	output logic [`SLURM16_ADDRESS_BITS-1:0] mem_addr,
	output logic mem_is_port,
	input  logic [`SLURM16_BITS-1:0] mem_rdata,
	input  logic [`SLURM16_REGISTER_BITS-1:0] rd_sel,
	output logic [`SLURM16_BITS-1:0] rd_data
);

	slurm16_pkg::slot_t slot_in;
	slurm16_pkg::slot_t slot;
	logic wr_en;
	logic [1:0] lane_mask;

	load_if load_bus();
	regwrite_if reg_bus();

	assign slot_in = '{
		instruction: in_instruction,
		alu_out:     in_alu_out,
		pc:          in_pc,
		mem_addr:    in_mem_addr,
		cond_pass:   in_cond_pass,
		is_nop:      in_is_nop,
		irq_return:  in_irq_return
	};

	assign lane_mask = slurm16_pkg::lane_mask(slot.mem_addr);	// From the latched address
	assign reg_bus.wr_en = wr_en;

	slurm16_stage_control u_control (
		.clk(clk),
		.reset(reset),
		.in_req(in_req),
		.in_ack(in_ack),
		.slot_in(slot_in),
		.slot(slot),
		.wr_en(wr_en),
		.load(load_bus.ctrl)
	);

	slurm16_load_unit u_load (
		.clk(clk),
		.reset(reset),
		.load(load_bus.unit),
		.mem_req(mem_req),
		.mem_ack(mem_ack),
		.mem_addr(mem_addr),
		.mem_is_port(mem_is_port),
		.mem_rdata(mem_rdata)
	);

	slurm16_cpu_writeback u_writeback (
		.slot(slot),
		.load_data(load_bus.data),
		.lane_mask(lane_mask),
		.wb(reg_bus.source)
	);

	slurm16_register_file u_regs (
		.clk(clk),
		.reset(reset),
		.wb(reg_bus.sink),
		.rd_sel(rd_sel),
		.rd_data(rd_data)
	);

endmodule

// ==== verif/slurm16_backend_tb.sv ====
/* Testbench for the slurm16 retirement backend: slot stimulus, memory and port
 * responder, register model and protocol and value assertions */
`include "slurm16_config.svh"

module slurm16_backend_tb;

	localparam int NUM_SLOTS = 252;	// 32 directed classes, then random
	localparam int TIMEOUT_CYCLES = 300 * 16;

	logic clk;
	logic reset;
	logic in_req;
	logic in_ack;
	logic [`SLURM16_BITS-1:0] in_instruction;
	logic [`SLURM16_BITS-1:0] in_alu_out;
	logic [`SLURM16_ADDRESS_BITS-1:0] in_pc;
	logic [`SLURM16_ADDRESS_BITS-1:0] in_mem_addr;
	logic in_cond_pass;
	logic in_is_nop;
	logic in_irq_return;
	logic mem_req;
	logic mem_ack;
	logic [`SLURM16_ADDRESS_BITS-1:0] mem_addr;
	logic mem_is_port;
	logic [`SLURM16_BITS-1:0] mem_rdata;
	logic [`SLURM16_REGISTER_BITS-1:0] rd_sel;
	logic [`SLURM16_BITS-1:0] rd_data;

	logic [15:0] model [16];	// Expected register contents
	logic check_reg;	// rd_data compared against the model
	logic expect_bus;	// Current slot needs a bus read
	logic expect_port;
	logic [31:0] seed;
	logic [31:0] resp_seed;
	logic [15:0] ins;
	logic [15:0] alu;
	logic [15:0] pc;
	logic [15:0] addr;
	logic cond;
	logic nop;
	logic irq;
	int value_errors;
	int protocol_errors;
	int slots_done;
	int cycles;

	slurm16_backend uut (.*);

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Destination and value of a retiring slot, from the class rules
	function automatic void predict_write(input logic [15:0] i_word, input logic [15:0] i_alu,
		input logic [15:0] i_pc, input logic [15:0] i_addr, input logic i_cond,
		input logic i_nop, input logic i_irq, output logic [3:0] sel,
		output logic [15:0] val, output logic bus);
		logic [15:0] word;
		logic [7:0] lane;
		word = i_addr ^ ((i_word[15:12] == 4'd7) ? 16'hc3a5 : 16'h5a3c);
		lane = i_addr[0] ? word[7:0] : word[15:8];	// Odd address is the low byte
		sel = 4'd0;
		val = 16'h0000;
		bus = 1'b0;
		if (i_irq) begin
			sel = 4'd14;
			val = i_pc;
		end else if (!i_nop) begin
			case (i_word[15:12])
				4'd1: begin
					sel = i_word[7:4];
					val = i_alu;
				end
				4'd2, 4'd9: begin
					sel = (i_word[15:12] == 4'd9 && !i_cond) ? 4'd0 : i_word[11:8];
					val = i_alu;
				end
				4'd3: begin
					sel = i_word[0] ? 4'd15 : 4'd0;
					val = i_pc + 16'd2;
				end
				4'd4, 4'd6, 4'd7: begin	// Loads and peeks unless the store bit is set
					bus = !i_word[3];
					sel = i_word[3] ? 4'd0 : i_word[11:8];
					val = (i_word[15:12] == 4'd4) ? {8'h00, lane} : word;
				end
				4'd5: begin
					bus = 1'b1;
					sel = i_word[11:8];
					val = {{8{lane[7]}}, lane};
				end
				4'd8: begin
					sel = 4'd14;
					val = i_pc;
				end
				4'd10: begin
					sel = i_cond ? i_word[3:0] : 4'd0;
					val = i_alu;
				end
				default: begin
				end
			endcase
		end
	endfunction

	task automatic retire_slot();
		logic [3:0] sel;
		logic [15:0] val;
		logic bus;
		predict_write(ins, alu, pc, addr, cond, nop, irq, sel, val, bus);
		@(posedge clk);
		in_instruction <= ins;
		in_alu_out <= alu;
		in_pc <= pc;
		in_mem_addr <= addr;
		in_cond_pass <= cond;
		in_is_nop <= nop;
		in_irq_return <= irq;
		expect_bus <= bus;
		expect_port <= (ins[15:12] == 4'd7);
		in_req <= 1'b1;
		@(negedge clk);
		while (!in_ack) @(negedge clk);
		if (sel != 4'd0) begin
			model[sel] = val;
		end
		@(posedge clk);
		in_req <= 1'b0;
		rd_sel <= sel;	// Target first, r0 when nothing is written
		check_reg <= 1'b1;
		seed = lcg_next(seed);
		@(posedge clk);
		rd_sel <= seed[19:16];
		@(posedge clk);
		check_reg <= 1'b0;
		@(negedge clk);
		while (in_ack) @(negedge clk);
		slots_done++;
	endtask

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// Four-phase memory and port responder with a random ack delay
	always @(posedge clk) begin
		resp_seed = lcg_next(resp_seed);
		if (mem_req && !mem_ack && resp_seed[17:16] != 2'd0) begin
			mem_ack <= 1'b1;
			mem_rdata <= mem_addr ^ (mem_is_port ? 16'hc3a5 : 16'h5a3c);
		end else if (!mem_req && mem_ack) begin
			mem_ack <= 1'b0;
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles with %0d slots retired", cycles, slots_done);
			$display("Verification failed");
			$finish;
		end
	end

	a_reset_idle: assert property (@(posedge clk) $fell(reset) |->
		!in_ack && !mem_req && !uut.wr_en)
		else begin
			protocol_errors++;
			$display("in_ack, mem_req or wr_en high after reset");
		end

	a_reg_value: assert property (@(posedge clk) disable iff (reset)
		check_reg |-> rd_data == model[rd_sel])
		else begin
			value_errors++;
			$display("mismatch rd_data r%0h: got %h expected %h", $sampled(rd_sel),
				$sampled(rd_data), model[$sampled(rd_sel)]);
		end

	a_ack_timing: assert property (@(posedge clk) disable iff (reset)
		$rose(in_ack) && !expect_bus |-> $past(in_req, 3) && !$past(in_req, 4))
		else begin
			protocol_errors++;
			$display("in_ack not 3 cycles after in_req on a slot without bus access");
		end

	a_ack_release: assert property (@(posedge clk) disable iff (reset)
		$fell(in_ack) |-> !$past(in_req))
		else begin
			protocol_errors++;
			$display("in_ack dropped while in_req was still high");
		end

	a_no_bus: assert property (@(posedge clk) disable iff (reset)
		in_req && !expect_bus |-> !mem_req)
		else begin
			protocol_errors++;
			$display("mem_req raised by a slot that needs no bus read");
		end

	a_port_sel: assert property (@(posedge clk) disable iff (reset)
		mem_req |-> mem_is_port == expect_port)
		else begin
			value_errors++;
			$display("mismatch mem_is_port: got %h expected %h", $sampled(mem_is_port),
				$sampled(expect_port));
		end

	a_bus_addr: assert property (@(posedge clk) disable iff (reset)
		mem_req |-> mem_addr == in_mem_addr)
		else begin
			value_errors++;
			$display("mismatch mem_addr: got %h expected %h", $sampled(mem_addr),
				$sampled(in_mem_addr));
		end

	initial begin
		reset = 1'b1;
		in_req = 1'b0;
		in_instruction = '0;
		in_alu_out = '0;
		in_pc = '0;
		in_mem_addr = '0;
		in_cond_pass = 1'b0;
		in_is_nop = 1'b0;
		in_irq_return = 1'b0;
		mem_ack = 1'b0;
		mem_rdata = '0;
		rd_sel = '0;
		check_reg = 1'b0;
		expect_bus = 1'b0;
		expect_port = 1'b0;
		seed = 32'h9f6d_7f3f;
		resp_seed = 32'h9f6d_7f3f;
		value_errors = 0;
		protocol_errors = 0;
		slots_done = 0;
		cycles = 0;
		for (int r = 0; r < 16; r++) begin
			model[r] = 16'h0000;
		end
		repeat (8) @(posedge clk);
		reset <= 1'b0;
		for (int i = 0; i < NUM_SLOTS; i++) begin
			seed = lcg_next(seed);
			ins = seed[31:16];
			if (i < 32) begin
				ins[15:12] = i[3:0];	// Every class with cond set and clear
			end
			seed = lcg_next(seed);
			alu = seed[31:16];
			seed = lcg_next(seed);
			pc = {seed[31:17], 1'b0};
			seed = lcg_next(seed);
			addr = seed[31:16];
			seed = lcg_next(seed);
			cond = (i < 32) ? i[4] : seed[31];
			nop = (i >= 32) && (seed[30:28] == 3'd0);
			irq = (i >= 32) && (seed[27:25] == 3'd0);
			retire_slot();
		end
		for (int r = 0; r < 16; r++) begin	// Final sweep of the whole file
			@(posedge clk);
			rd_sel <= r[3:0];
			check_reg <= 1'b1;
		end
		@(posedge clk);
		check_reg <= 1'b0;
		@(posedge clk);
		$display("errors: %0d value, %0d protocol, over %0d slots", value_errors,
			protocol_errors, slots_done);
		if (value_errors == 0 && protocol_errors == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

// ==== slurm16_backend.f ====
+incdir+logic
logic/slurm16_pkg.sv
logic/slurm16_backend_ifs.sv
logic/slurm16_stage_control.sv
logic/slurm16_load_unit.sv
logic/slurm16_cpu_writeback.sv
logic/slurm16_register_file.sv
logic/slurm16_backend.sv
verif/slurm16_backend_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the slurm16 backend testbench with Verilator, run it and scan the log
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module slurm16_backend_tb \
	-f slurm16_backend.f -Mdir obj_dir > build.log 2>&1 \
	|| { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vslurm16_backend_tb > sim.log 2>&1
sim_status=$?
cat sim.log
grep -q "Verification failed" sim.log && exit 1
[ "$sim_status" -eq 0 ] || { echo "simulator exited with status $sim_status"; exit 1; }
grep -q "Verification passed" sim.log || { echo "run ended without a result"; exit 1; }
exit 0
